// ==== hw/xlat_pkg.sv ====
package xlat_pkg;

   // --------------------------------------------------------------------------
   // Master side, word addressed
   // --------------------------------------------------------------------------

   localparam int AV_ADDRESS_W = 16;

   // Bursts of 1 to 8 words
   localparam int AV_BURSTCOUNT_W = 4;

   localparam int DATA_W = 32;
   localparam int BYTEEN_W = 4;

   // --------------------------------------------------------------------------
   // Word to byte scaling
   // --------------------------------------------------------------------------

   localparam int SYMBOLS_PER_WORD = 4;
   localparam int WORD_SHIFT = 2;

   // --------------------------------------------------------------------------
   // Fabric side, byte addressed
   // --------------------------------------------------------------------------

   localparam int UAV_ADDRESS_W = AV_ADDRESS_W + WORD_SHIFT;
   localparam int UAV_BURSTCOUNT_W = 6;

   // Single covers idle, reads and the first write beat.
   // Burst covers the continuation beats of a write burst.
   typedef enum logic {
      ST_SINGLE,
      ST_BURST
   } burst_state_t;

endpackage

// ==== hw/burst_ctrl.sv ====
module burst_ctrl
   import xlat_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic write,
   input  logic uav_waitrequest,
   input  logic last_beat,
   input  logic first_is_last,
   output logic load,
   output logic step,
   output logic in_burst
);

   burst_state_t state;
   burst_state_t state_next;
   logic         write_accept;

   // A write beat is taken on any edge where the fabric does not stall
   assign write_accept = write & ~uav_waitrequest;

   // --------------------------------------------------------------------------
   // Next state and register strobes
   // --------------------------------------------------------------------------

   always_comb begin
      load       = 1'b0;
      step       = 1'b0;
      state_next = state;

      case (state)
         ST_SINGLE: begin
            // First beat seeds the counter and the address register
            load = write_accept;
            if (write_accept && !first_is_last) begin
               state_next = ST_BURST;
            end
         end

         ST_BURST: begin
            step = write_accept;
            // Leave the burst once the final beat is taken
            if (write_accept && last_beat) begin
               state_next = ST_SINGLE;
            end
         end

         default: begin
            state_next = ST_SINGLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= ST_SINGLE;
      end else begin
         state <= state_next;
      end
   end

   assign in_burst = (state == ST_BURST);

endmodule

// ==== hw/beat_counter.sv ====
module beat_counter
   import xlat_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic [AV_BURSTCOUNT_W-1:0]  burstcount,
   input  logic                        load,
   input  logic                        step,
   input  logic                        in_burst,
   output logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   output logic                        last_beat,
   output logic                        first_is_last
);

   logic [UAV_BURSTCOUNT_W-1:0] scaled_count;
   logic [UAV_BURSTCOUNT_W-1:0] remain;
   logic [UAV_BURSTCOUNT_W-1:0] word_bytes;

   assign word_bytes = UAV_BURSTCOUNT_W'(SYMBOLS_PER_WORD);

   // Word count to byte count
   assign scaled_count = UAV_BURSTCOUNT_W'(burstcount) << WORD_SHIFT;

   // Single-word write, no continuation beats follow
   assign first_is_last = (scaled_count == word_bytes);

   // --------------------------------------------------------------------------
   // Remaining bytes for the next beat
   // --------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         remain <= '0;
      end else if (load) begin
         // First beat already carries one word
         remain <= scaled_count - word_bytes;
      end else if (step) begin
         remain <= remain - word_bytes;
      end
   end

   // The flag is only looked at while a burst is running
   assign last_beat = (remain == word_bytes);

   // First beat and reads go out with the live count
   always_comb begin
      if (in_burst) begin
         uav_burstcount = remain;
      end else begin
         uav_burstcount = scaled_count;
      end
   end

endmodule

// ==== hw/addr_gen.sv ====
module addr_gen
   import xlat_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic [AV_ADDRESS_W-1:0]  address,
   input  logic                     load,
   input  logic                     step,
   input  logic                     in_burst,
   output logic [UAV_ADDRESS_W-1:0] uav_address
);

   logic [UAV_ADDRESS_W-1:0] byte_addr;
   logic [UAV_ADDRESS_W-1:0] addr_reg;
   logic [UAV_ADDRESS_W-1:0] word_bytes;

   assign word_bytes = UAV_ADDRESS_W'(SYMBOLS_PER_WORD);

   // Word address to byte address
   assign byte_addr = UAV_ADDRESS_W'(address) << WORD_SHIFT;

   // --------------------------------------------------------------------------
   // Address of the next beat
   // --------------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_reg <= '0;
      end else if (load) begin
         // Second beat sits one word above the first
         addr_reg <= byte_addr + word_bytes;
      end else if (step) begin
         addr_reg <= addr_reg + word_bytes;
      end
   end

   // Master address stays at the burst base, so continuation beats
   // take the register instead
   always_comb begin
      if (in_burst) begin
         uav_address = addr_reg;
      end else begin
         uav_address = byte_addr;
      end
   end

endmodule

// ==== hw/master_xlat_top.sv ====
module master_xlat_top
   import xlat_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,

   // Master side, word addressed
   input  logic                        write,
   input  logic                        read,
   input  logic [AV_ADDRESS_W-1:0]     address,
   input  logic [AV_BURSTCOUNT_W-1:0]  burstcount,
   input  logic [DATA_W-1:0]           writedata,
   input  logic [BYTEEN_W-1:0]         byteenable,
   output logic                        waitrequest,
   output logic [DATA_W-1:0]           readdata,
   output logic                        readdatavalid,

   // Fabric side, byte addressed
   output logic                        uav_write,
   output logic                        uav_read,
   output logic [UAV_ADDRESS_W-1:0]    uav_address,
   output logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   output logic [DATA_W-1:0]           uav_writedata,
   output logic [BYTEEN_W-1:0]         uav_byteenable,
   input  logic                        uav_waitrequest,
   input  logic [DATA_W-1:0]           uav_readdata,
   input  logic                        uav_readdatavalid
);

   logic load;
   logic step;
   logic in_burst;
   logic last_beat;
   logic first_is_last;

   // --------------------------------------------------------------------------
   // Straight pass-through
   // --------------------------------------------------------------------------

   assign uav_write      = write;
   assign uav_read       = read;
   assign uav_writedata  = writedata;
   assign uav_byteenable = byteenable;

   // Fabric stall goes back to the master unchanged
   assign waitrequest   = uav_waitrequest;
   assign readdata      = uav_readdata;
   assign readdatavalid = uav_readdatavalid;

   // --------------------------------------------------------------------------
   // Write burst sequencing
   // --------------------------------------------------------------------------

   burst_ctrl u_burst_ctrl (
      .clk             (clk),
      .reset           (reset),
      .write           (write),
      .uav_waitrequest (uav_waitrequest),
      .last_beat       (last_beat),
      .first_is_last   (first_is_last),
      .load            (load),
      .step            (step),
      .in_burst        (in_burst)
   );

   beat_counter u_beat_counter (
      .clk            (clk),
      .reset          (reset),
      .burstcount     (burstcount),
      .load           (load),
      .step           (step),
      .in_burst       (in_burst),
      .uav_burstcount (uav_burstcount),
      .last_beat      (last_beat),
      .first_is_last  (first_is_last)
   );

   addr_gen u_addr_gen (
      .clk         (clk),
      .reset       (reset),
      .address     (address),
      .load        (load),
      .step        (step),
      .in_burst    (in_burst),
      .uav_address (uav_address)
   );

endmodule

// ==== dv/tb_clock.sv ====
module tb_clock (
   output logic clk
);

   localparam int PERIOD = 20;

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// ==== dv/xlat_assertions.sv ====
module xlat_assertions
   import xlat_pkg::*;
(
   input logic                        clk,
   input logic                        reset,
   input logic                        uav_write,
   input logic                        uav_waitrequest,
   input logic [UAV_ADDRESS_W-1:0]    uav_address,
   input logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount,
   input logic                        in_burst,
   input logic                        last_beat
);

   // A stalled write beat keeps its address and remaining count
   assert property (@(posedge clk) disable iff (reset)
      (uav_write && uav_waitrequest) |=> ($stable(uav_address) && $stable(uav_burstcount)))
      else $error("uav_address or uav_burstcount changed while the write was stalled");

   // No burst can be in progress while reset is applied
   assert property (@(posedge clk) reset |-> !in_burst)
      else $error("in_burst is high during reset");

   // Taking the last beat ends the burst
   assert property (@(posedge clk) disable iff (reset)
      (in_burst && uav_write && !uav_waitrequest && last_beat)
      |=> (burst_state_t'(in_burst) == ST_SINGLE))
      else $error("burst state did not return to single after the last beat");

endmodule

bind master_xlat_top xlat_assertions u_xlat_assertions (
   .clk             (clk),
   .reset           (reset),
   .uav_write       (uav_write),
   .uav_waitrequest (uav_waitrequest),
   .uav_address     (uav_address),
   .uav_burstcount  (uav_burstcount),
   .in_burst        (in_burst),
   .last_beat       (last_beat)
);

// ==== dv/tb_master_xlat.sv ====
module tb_master_xlat
   import xlat_pkg::*;
();

   localparam int STIM_DELAY   = 1;
   localparam int RESET_CYCLES = 10;
   localparam int WAIT_LIMIT   = 64;
   localparam int NUM_CMDS     = 10;

   // One master command of the table
   typedef struct packed {
      logic                       is_read;
      logic [AV_ADDRESS_W-1:0]    word_addr;
      logic [AV_BURSTCOUNT_W-1:0] words;
      logic [DATA_W-1:0]          seed;
      logic                       stall;
   } cmd_t;

   logic                        clk;
   logic                        reset;
   logic                        write;
   logic                        read;
   logic [AV_ADDRESS_W-1:0]     address;
   logic [AV_BURSTCOUNT_W-1:0]  burstcount;
   logic [DATA_W-1:0]           writedata;
   logic [BYTEEN_W-1:0]         byteenable;
   logic                        waitrequest;
   logic [DATA_W-1:0]           readdata;
   logic                        readdatavalid;
   logic                        uav_write;
   logic                        uav_read;
   logic [UAV_ADDRESS_W-1:0]    uav_address;
   logic [UAV_BURSTCOUNT_W-1:0] uav_burstcount;
   logic [DATA_W-1:0]           uav_writedata;
   logic [BYTEEN_W-1:0]         uav_byteenable;
   logic                        uav_waitrequest;
   logic [DATA_W-1:0]           uav_readdata;
   logic                        uav_readdatavalid;

   cmd_t        cmd_table [NUM_CMDS];
   logic        stall_en;
   logic [31:0] lfsr_state;
   int          err_count = 0;
   int          timeout_count = 0;

   // Beats accepted by the fabric model
   logic [UAV_ADDRESS_W-1:0]    rec_address [$];
   logic [UAV_BURSTCOUNT_W-1:0] rec_count [$];
   logic [DATA_W-1:0]           rec_data [$];
   logic [BYTEEN_W-1:0]         rec_enable [$];
   logic                        rec_is_write [$];
   logic                        rec_is_read [$];
   logic [DATA_W-1:0]           read_queue [$];

   tb_clock u_clock (
      .clk (clk)
   );

   master_xlat_top UUT (
      .clk               (clk),
      .reset             (reset),
      .write             (write),
      .read              (read),
      .address           (address),
      .burstcount        (burstcount),
      .writedata         (writedata),
      .byteenable        (byteenable),
      .waitrequest       (waitrequest),
      .readdata          (readdata),
      .readdatavalid     (readdatavalid),
      .uav_write         (uav_write),
      .uav_read          (uav_read),
      .uav_address       (uav_address),
      .uav_burstcount    (uav_burstcount),
      .uav_writedata     (uav_writedata),
      .uav_byteenable    (uav_byteenable),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid)
   );

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'hD000_0001;
      end
      return s >> 1;
   endfunction

   // Byte enables of beat k as a simple pattern on the data seed
   function automatic logic [BYTEEN_W-1:0] enable_for(input logic [DATA_W-1:0] seed,
                                                      input int k);
      return BYTEEN_W'(seed) ^ BYTEEN_W'(k);
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   // Hold the command until the fabric takes it
   task automatic wait_accept();
      int cycles;
      bit accepted;
      cycles = 0;
      accepted = 1'b0;
      while (!accepted && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         check_value("waitrequest", 32'(waitrequest), 32'(uav_waitrequest));
         accepted = !waitrequest;
         cycles++;
      end
      if (!accepted) begin
         $display("Timeout at %0t: the fabric never accepted the command", $time);
         timeout_count++;
      end
      @(posedge clk);
      #STIM_DELAY;
   endtask

   task automatic run_write(input cmd_t c);
      int first;
      first = rec_address.size();
      for (int k = 0; k < int'(c.words); k++) begin
         write      = 1'b1;
         read       = 1'b0;
         address    = c.word_addr;
         burstcount = c.words;
         writedata  = c.seed + DATA_W'(k);
         byteenable = enable_for(c.seed, k);
         wait_accept();
      end
      write = 1'b0;
      check_value("accepted write beats", 32'(rec_address.size() - first), 32'(c.words));
      // Beat k carries base + 4k and 4(N - k) bytes remaining
      for (int k = 0; k < int'(c.words) && first + k < rec_address.size(); k++) begin
         check_value("uav_write", 32'(rec_is_write[first + k]), 32'd1);
         check_value("uav_read", 32'(rec_is_read[first + k]), 32'd0);
         check_value("uav_address", 32'(rec_address[first + k]),
                     32'(c.word_addr) * 32'd4 + 32'(k) * 32'd4);
         check_value("uav_burstcount", 32'(rec_count[first + k]),
                     32'd4 * (32'(c.words) - 32'(k)));
         check_value("uav_writedata", rec_data[first + k], c.seed + DATA_W'(k));
         check_value("uav_byteenable", 32'(rec_enable[first + k]),
                     32'(enable_for(c.seed, k)));
      end
   endtask

   task automatic run_read(input cmd_t c);
      int first;
      int got;
      int cycles;
      first = rec_address.size();
      got = 0;
      cycles = 0;
      read       = 1'b1;
      write      = 1'b0;
      address    = c.word_addr;
      burstcount = c.words;
      wait_accept();
      read = 1'b0;
      check_value("accepted read commands", 32'(rec_address.size() - first), 32'd1);
      if (rec_address.size() > first) begin
         check_value("uav_write", 32'(rec_is_write[first]), 32'd0);
         check_value("uav_read", 32'(rec_is_read[first]), 32'd1);
         check_value("read uav_address", 32'(rec_address[first]), 32'(c.word_addr) * 32'd4);
         check_value("read uav_burstcount", 32'(rec_count[first]), 32'd4 * 32'(c.words));
      end
      while (got < int'(c.words) && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         if (readdatavalid) begin
            check_value("readdata", readdata, 32'(c.word_addr) * 32'd4 + 32'(got));
            got++;
         end
         cycles++;
      end
      if (got < int'(c.words)) begin
         $display("Timeout at %0t: only %0d of %0d read beats returned", $time, got, c.words);
         timeout_count++;
      end
      @(posedge clk);
      #STIM_DELAY;
   endtask

   // ------------------------------------------------------------------------
   // Fabric slave model
   // ------------------------------------------------------------------------

   initial begin
      logic stall_now;
      uav_waitrequest   = 1'b0;
      uav_readdata      = '0;
      uav_readdatavalid = 1'b0;
      lfsr_state        = 32'hbeca2976;
      forever begin
         @(posedge clk);
         stall_now = stall_en;
         #STIM_DELAY;
         if (stall_now) begin
            uav_waitrequest = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
         end else begin
            uav_waitrequest = 1'b0;
         end
         if (read_queue.size() > 0) begin
            uav_readdatavalid = 1'b1;
            uav_readdata = read_queue.pop_front();
         end else begin
            uav_readdatavalid = 1'b0;
            uav_readdata = '0;
         end
         // Inputs are settled here and the beat is taken at the next edge
         @(negedge clk);
         if (!reset && (uav_write || uav_read) && !uav_waitrequest) begin
            rec_address.push_back(uav_address);
            rec_count.push_back(uav_burstcount);
            rec_data.push_back(uav_writedata);
            rec_enable.push_back(uav_byteenable);
            rec_is_write.push_back(uav_write);
            rec_is_read.push_back(uav_read);
            if (uav_read) begin
               for (int i = 0; i < int'(uav_burstcount) / SYMBOLS_PER_WORD; i++) begin
                  read_queue.push_back(DATA_W'(uav_address) + DATA_W'(i));
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Command table and main sequence
   // ------------------------------------------------------------------------

   initial begin
      reset      = 1'b1;
      write      = 1'b0;
      read       = 1'b0;
      address    = '0;
      burstcount = '0;
      writedata  = '0;
      byteenable = '0;
      stall_en   = 1'b0;

      // is_read, word address, words, data seed, stall
      cmd_table[0] = '{1'b0, 16'h0010, 4'd1, 32'h1000_0000, 1'b0};
      cmd_table[1] = '{1'b0, 16'h0100, 4'd4, 32'h2000_0010, 1'b0};
      cmd_table[2] = '{1'b0, 16'h2000, 4'd8, 32'h3000_0020, 1'b0};
      cmd_table[3] = '{1'b0, 16'h0345, 4'd5, 32'h4000_0030, 1'b1};
      cmd_table[4] = '{1'b1, 16'h0400, 4'd1, 32'h0000_0000, 1'b0};
      cmd_table[5] = '{1'b1, 16'h0800, 4'd6, 32'h0000_0000, 1'b1};
      // Burst directly followed by a single word
      cmd_table[6] = '{1'b0, 16'h1230, 4'd3, 32'h5000_0040, 1'b1};
      cmd_table[7] = '{1'b0, 16'h0555, 4'd1, 32'h6000_0050, 1'b1};
      cmd_table[8] = '{1'b0, 16'hfff0, 4'd8, 32'h7000_0060, 1'b1};
      cmd_table[9] = '{1'b1, 16'hfff8, 4'd2, 32'h0000_0000, 1'b0};

      repeat (RESET_CYCLES) @(posedge clk);
      #STIM_DELAY;
      reset = 1'b0;
      @(posedge clk);
      #STIM_DELAY;

      for (int i = 0; i < NUM_CMDS; i++) begin
         stall_en = cmd_table[i].stall;
         if (cmd_table[i].is_read) begin
            run_read(cmd_table[i]);
         end else begin
            run_write(cmd_table[i]);
         end
      end

      $display("Summary: %0d value errors, %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== list.f ====
hw/xlat_pkg.sv
hw/burst_ctrl.sv
hw/beat_counter.sv
hw/addr_gen.sv
hw/master_xlat_top.sv
dv/tb_clock.sv
dv/xlat_assertions.sv
dv/tb_master_xlat.sv

// ==== Makefile ====
# Verilator simulation of the word-to-byte command translator

VERILATOR ?= verilator
TOP       ?= tb_master_xlat
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= >>> PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run counts as passed only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
